//--- hdl/scu_settings.svh
//--------------------------------------------------------------------------
// widths, counts and byte offsets of the system control register block
//--------------------------------------------------------------------------
`ifndef SCU_SETTINGS_SVH
`define SCU_SETTINGS_SVH

`default_nettype none

`define SCU_ADDR_W      24
`define SCU_DATA_W      32
`define SCU_MOD_NUM     11    // resettable modules
`define SCU_UTS_W       64
`define SCU_INT_NUM     3     // bit 0 reserved, 1 and 2 are sw_int0/1
`define SCU_RST_STAGES  2     // reset release pipeline depth

// register map, byte offsets
`define SCU_OFS_SW_INT        'h00
`define SCU_OFS_INT_STS       'h04
`define SCU_OFS_INT_EN        'h08
`define SCU_OFS_PCIE_INT      'h0C
`define SCU_OFS_PCIE_ACK      'h10
`define SCU_OFS_PREWARN       'h14
`define SCU_OFS_SW_RST_REQ    'h18
`define SCU_OFS_MOD_RST_REQ   'h1C
`define SCU_OFS_MOD_RST_MASK  'h20
`define SCU_OFS_RST_STS       'h24
`define SCU_OFS_UTS_L         'h28
`define SCU_OFS_UTS_H         'h2C
`define SCU_OFS_UTS_CLR       'h30
`define SCU_OFS_PIN_STS       'h34

`default_nettype wire

`endif

//--- hdl/scu_pkg.sv
//--------------------------------------------------------------------------
// bus, register and status types shared by the scu blocks and testbench
//--------------------------------------------------------------------------
`include "scu_settings.svh"
`default_nettype none

package scu_pkg;

  typedef enum logic [1:0] {
    SCU_RESP_OKAY  = 2'b00,
    SCU_RESP_ERROR = 2'b01
  } scu_resp_e;

  // ahb-lite master request
  typedef struct packed {
    logic                   sel;
    logic                   ready;
    logic [1:0]             trans;
    logic                   write;
    logic [`SCU_ADDR_W-1:0] addr;
    logic [`SCU_DATA_W-1:0] wdata;
  } scu_ahb_req_t;

  typedef struct packed {
    logic                   readyout;
    scu_resp_e              resp;
    logic [`SCU_DATA_W-1:0] rdata;
  } scu_ahb_rsp_t;

  // one data phase access
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [`SCU_ADDR_W-1:0] addr;
    logic [`SCU_DATA_W-1:0] wdata;
  } scu_reg_req_t;

  // listed msb first, riscv_debug lands in bit 0
  typedef struct packed {
    logic ddr;
    logic mac;
    logic dma;
    logic jtag2ahb;
    logic timer1;
    logic timer0;
    logic uart;
    logic uncore_nic;
    logic core_nic;
    logic riscv;
    logic riscv_debug;
  } scu_mod_rst_t;

  // reset control word, raw on the bus or split per module
  typedef union packed {
    logic [`SCU_DATA_W-1:0] raw;
    struct packed {
      logic [`SCU_DATA_W-`SCU_MOD_NUM-1:0] pad;
      scu_mod_rst_t                        mods;
    } f;
  } scu_mod_word_u;

  typedef struct packed {
    logic [1:0]              sw_int;
    logic [`SCU_INT_NUM-1:0] int_en;
    logic [`SCU_INT_NUM-1:0] int_w1c;   // one cycle, on INT_STS write
    logic                    pcie_int;
    logic                    ack_clr;
  } scu_irq_ctl_t;

  typedef struct packed {
    logic [`SCU_INT_NUM-1:0] int_sts;
    logic [2:0]              ack;
    logic                    ack_pulse;  // rising edge of ack line 0
  } scu_irq_sts_t;

  typedef struct packed {
    logic ddr_init_done;
    logic pcie_lnk_up;
    logic msi_en;
    logic msix_en;
    logic boot_strap;
  } scu_pin_sts_t;

  typedef enum logic [3:0] {
    REG_SW_INT, REG_INT_STS, REG_INT_EN, REG_PCIE_INT, REG_PCIE_ACK,
    REG_PREWARN, REG_SW_RST_REQ, REG_MOD_RST_REQ, REG_MOD_RST_MASK,
    REG_RST_STS, REG_UTS_L, REG_UTS_H, REG_UTS_CLR, REG_PIN_STS, REG_NONE
  } scu_reg_idx_e;

endpackage

`default_nettype wire

//--- hdl/scu_ahb_slave.sv
//--------------------------------------------------------------------------
// ahb-lite word slave, turns each data phase into one register access
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "scu_settings.svh"
`default_nettype none

module scu_ahb_slave import scu_pkg::*; (
  input  logic                   pcie_clk_i,
  input  logic                   scu_register_rst_n_s,
  input  scu_ahb_req_t           ahb_req_i,
  input  logic [`SCU_DATA_W-1:0] reg_rdata_i,
  input  logic                   addr_err_i,
  output scu_ahb_rsp_t           ahb_rsp_o,
  output scu_reg_req_t           reg_req_o
);

  logic                   dp_valid_q;   // data phase pending
  logic                   dp_write_q;
  logic [`SCU_ADDR_W-1:0] dp_addr_q;
  logic                   err_last_q;   // second error cycle
  logic                   err_first;

  assign err_first = dp_valid_q & addr_err_i;

  // address phase capture
  always_ff @(posedge pcie_clk_i or negedge scu_register_rst_n_s) begin
    if (!scu_register_rst_n_s) begin
      dp_valid_q <= 1'b0;
      dp_write_q <= 1'b0;
      dp_addr_q  <= '0;
      err_last_q <= 1'b0;
    end else begin
      err_last_q <= err_first;
      if (err_first) begin
        dp_valid_q <= 1'b0;   // faulty access ends here
      end else if (ahb_req_i.ready) begin
        dp_valid_q <= ahb_req_i.sel & ahb_req_i.trans[1];   // nonseq or seq
        dp_write_q <= ahb_req_i.write;
        dp_addr_q  <= ahb_req_i.addr;
      end
    end
  end

  always_comb begin
    reg_req_o.wr    = dp_valid_q & dp_write_q;
    reg_req_o.rd    = dp_valid_q & ~dp_write_q;
    reg_req_o.addr  = dp_addr_q;
    reg_req_o.wdata = ahb_req_i.wdata;   // hwdata arrives with the data phase
  end

  // error takes one wait cycle then completes
  always_comb begin
    ahb_rsp_o.readyout = ~err_first;
    ahb_rsp_o.resp     = (err_first | err_last_q) ? SCU_RESP_ERROR : SCU_RESP_OKAY;
    ahb_rsp_o.rdata    = reg_rdata_i;
  end

  a_err_two_cycle: assert property (
    @(posedge pcie_clk_i) disable iff (!scu_register_rst_n_s)
    $rose(ahb_rsp_o.resp == SCU_RESP_ERROR) |->
      !ahb_rsp_o.readyout ##1 (ahb_rsp_o.readyout && ahb_rsp_o.resp == SCU_RESP_ERROR)
  );

endmodule

`default_nettype wire

//--- hdl/scu_regfile.sv
//--------------------------------------------------------------------------
// register decode, software registers and read mux of the scu
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "scu_settings.svh"
`default_nettype none

module scu_regfile import scu_pkg::*; (
  input  logic                   pcie_clk_i,
  input  logic                   scu_register_rst_n_s,
  input  scu_reg_req_t           reg_req_i,
  input  scu_irq_sts_t           irq_sts_i,
  input  scu_mod_rst_t           mod_rst_i,
  input  logic [`SCU_DATA_W-1:0] uts_lo_i,
  input  logic [`SCU_DATA_W-1:0] uts_hi_snap_i,
  input  scu_pin_sts_t           pin_sts_i,
  output logic [`SCU_DATA_W-1:0] reg_rdata_o,
  output logic                   addr_err_o,
  output scu_irq_ctl_t           irq_ctl_o,
  output scu_mod_rst_t           mod_req_o,
  output scu_mod_rst_t           mod_mask_o,
  output logic                   sw_rst_req_o,
  output logic                   prewarn_o,
  output logic                   uts_clr_o,
  output logic                   uts_rd_lo_o
);

  scu_reg_idx_e            idx;
  logic [1:0]              sw_int_q;
  logic [`SCU_INT_NUM-1:0] int_en_q;
  logic                    pcie_int_q;
  logic                    ack_clr_q;
  logic                    prewarn_q;
  logic                    sw_rst_req_q;
  scu_mod_word_u           mod_req_q;
  scu_mod_word_u           mod_mask_q;
  scu_mod_word_u           rst_sts_w;

  // keeps only the module bits of a bus word
  function automatic scu_mod_word_u mod_word(input logic [`SCU_DATA_W-1:0] w);
    scu_mod_word_u u;
    u.raw   = w;
    u.f.pad = '0;
    return u;
  endfunction

  always_comb begin
    case (reg_req_i.addr)
      `SCU_OFS_SW_INT:       idx = REG_SW_INT;
      `SCU_OFS_INT_STS:      idx = REG_INT_STS;
      `SCU_OFS_INT_EN:       idx = REG_INT_EN;
      `SCU_OFS_PCIE_INT:     idx = REG_PCIE_INT;
      `SCU_OFS_PCIE_ACK:     idx = REG_PCIE_ACK;
      `SCU_OFS_PREWARN:      idx = REG_PREWARN;
      `SCU_OFS_SW_RST_REQ:   idx = REG_SW_RST_REQ;
      `SCU_OFS_MOD_RST_REQ:  idx = REG_MOD_RST_REQ;
      `SCU_OFS_MOD_RST_MASK: idx = REG_MOD_RST_MASK;
      `SCU_OFS_RST_STS:      idx = REG_RST_STS;
      `SCU_OFS_UTS_L:        idx = REG_UTS_L;
      `SCU_OFS_UTS_H:        idx = REG_UTS_H;
      `SCU_OFS_UTS_CLR:      idx = REG_UTS_CLR;
      `SCU_OFS_PIN_STS:      idx = REG_PIN_STS;
      default:               idx = REG_NONE;
    endcase
  end

  assign addr_err_o = (reg_req_i.wr | reg_req_i.rd) & (idx == REG_NONE);

  //------------------------------------------------------------------------
  // software registers
  //------------------------------------------------------------------------
  always_ff @(posedge pcie_clk_i or negedge scu_register_rst_n_s) begin
    if (!scu_register_rst_n_s) begin
      sw_int_q     <= '0;
      int_en_q     <= '0;
      pcie_int_q   <= 1'b0;
      ack_clr_q    <= 1'b0;
      prewarn_q    <= 1'b0;
      sw_rst_req_q <= 1'b0;
      mod_req_q    <= '0;
      mod_mask_q   <= '0;
    end else begin
      if (reg_req_i.wr) begin
        case (idx)
          REG_SW_INT:       sw_int_q     <= reg_req_i.wdata[1:0];
          REG_INT_EN:       int_en_q     <= reg_req_i.wdata[`SCU_INT_NUM-1:0];
          REG_PREWARN:      prewarn_q    <= reg_req_i.wdata[0];
          REG_SW_RST_REQ:   sw_rst_req_q <= reg_req_i.wdata[0];
          REG_MOD_RST_REQ:  mod_req_q    <= mod_word(reg_req_i.wdata);
          REG_MOD_RST_MASK: mod_mask_q   <= mod_word(reg_req_i.wdata);
          default: ;
        endcase
      end
      // ack edge beats a software write
      if (irq_sts_i.ack_pulse) begin
        pcie_int_q <= 1'b0;
      end else if (reg_req_i.wr && idx == REG_PCIE_INT) begin
        pcie_int_q <= reg_req_i.wdata[0];
      end
      // lands while pcie_int is already set
      ack_clr_q <= reg_req_i.wr & (idx == REG_PCIE_INT) & reg_req_i.wdata[0];
    end
  end

  always_comb begin
    irq_ctl_o.sw_int   = sw_int_q;
    irq_ctl_o.int_en   = int_en_q;
    irq_ctl_o.int_w1c  = (reg_req_i.wr && idx == REG_INT_STS) ?
                         reg_req_i.wdata[`SCU_INT_NUM-1:0] : '0;
    irq_ctl_o.pcie_int = pcie_int_q;
    irq_ctl_o.ack_clr  = ack_clr_q;
  end

  assign mod_req_o    = mod_req_q.f.mods;
  assign mod_mask_o   = mod_mask_q.f.mods;
  assign sw_rst_req_o = sw_rst_req_q;
  assign prewarn_o    = prewarn_q;
  assign uts_clr_o    = reg_req_i.wr & (idx == REG_UTS_CLR) & reg_req_i.wdata[0];
  assign uts_rd_lo_o  = reg_req_i.rd & (idx == REG_UTS_L);
  assign rst_sts_w    = mod_word(`SCU_DATA_W'(mod_rst_i));

  //------------------------------------------------------------------------
  // read mux, unused bits read 0
  //------------------------------------------------------------------------
  always_comb begin
    reg_rdata_o = '0;
    case (idx)
      REG_SW_INT:       reg_rdata_o[1:0] = sw_int_q;
      REG_INT_STS:      reg_rdata_o[`SCU_INT_NUM-1:0] = irq_sts_i.int_sts;
      REG_INT_EN:       reg_rdata_o[`SCU_INT_NUM-1:0] = int_en_q;
      REG_PCIE_INT:     reg_rdata_o[0] = pcie_int_q;
      REG_PCIE_ACK:     reg_rdata_o[2:0] = irq_sts_i.ack;
      REG_PREWARN:      reg_rdata_o[0] = prewarn_q;
      REG_SW_RST_REQ:   reg_rdata_o[0] = sw_rst_req_q;
      REG_MOD_RST_REQ:  reg_rdata_o = mod_req_q.raw;
      REG_MOD_RST_MASK: reg_rdata_o = mod_mask_q.raw;
      REG_RST_STS:      reg_rdata_o = rst_sts_w.raw;
      REG_UTS_L:        reg_rdata_o = uts_lo_i;
      REG_UTS_H:        reg_rdata_o = uts_hi_snap_i;
      REG_PIN_STS:      reg_rdata_o[$bits(scu_pin_sts_t)-1:0] = pin_sts_i;
      default: ;
    endcase
  end

  // a word offset inside the register map never reports an error
  a_err_no_hit: assert property (
    @(posedge pcie_clk_i) disable iff (!scu_register_rst_n_s)
    addr_err_o |-> !(reg_req_i.addr[1:0] == 2'b00 &&
                     reg_req_i.addr <= `SCU_OFS_PIN_STS)
  );

endmodule

`default_nettype wire

//--- hdl/scu_irq_ctrl.sv
//--------------------------------------------------------------------------
// software interrupt status, pcie acknowledge tracking and scu interrupt
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "scu_settings.svh"
`default_nettype none

module scu_irq_ctrl import scu_pkg::*; (
  input  logic         pcie_clk_i,
  input  logic         scu_register_rst_n_s,
  input  scu_irq_ctl_t irq_ctl_i,
  input  logic [2:0]   pcie_int_ack_i,
  output scu_irq_sts_t irq_sts_o,
  output logic         scu_int_o
);

  logic [1:0]              sw_int_d;
  logic                    ack0_d;
  logic [1:0]              sw_rise;
  logic                    ack_rise;
  logic [`SCU_INT_NUM-1:0] int_set;
  logic [`SCU_INT_NUM-1:0] int_sts_q;
  logic                    ack_lvl_q;
  logic [2:1]              ack_sticky_q;   // reset and wdt prewarning acks

  assign sw_rise  = irq_ctl_i.sw_int & ~sw_int_d;
  assign ack_rise = pcie_int_ack_i[0] & ~ack0_d;
  assign int_set  = {sw_rise, 1'b0};   // bit 0 was the watchdog

  always_ff @(posedge pcie_clk_i or negedge scu_register_rst_n_s) begin
    if (!scu_register_rst_n_s) begin
      sw_int_d     <= '0;
      ack0_d       <= 1'b0;
      int_sts_q    <= '0;
      ack_lvl_q    <= 1'b0;
      ack_sticky_q <= '0;
    end else begin
      sw_int_d  <= irq_ctl_i.sw_int;
      ack0_d    <= pcie_int_ack_i[0];
      int_sts_q <= (int_sts_q & ~irq_ctl_i.int_w1c) | int_set;   // set wins
      if (irq_ctl_i.pcie_int && irq_ctl_i.ack_clr) begin
        ack_lvl_q <= 1'b0;
      end else if (ack_rise) begin
        ack_lvl_q <= 1'b1;
      end
      ack_sticky_q <= ack_sticky_q | pcie_int_ack_i[2:1];
    end
  end

  always_comb begin
    irq_sts_o.int_sts   = int_sts_q;
    irq_sts_o.ack       = {ack_sticky_q, ack_lvl_q};
    irq_sts_o.ack_pulse = ack_rise;
  end

  assign scu_int_o = |(int_sts_q & irq_ctl_i.int_en);   // level, high active

endmodule

`default_nettype wire

//--- hdl/scu_rst_ctrl.sv
//--------------------------------------------------------------------------
// per-module reset generation, active high, released through a pipeline
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "scu_settings.svh"
`default_nettype none

module scu_rst_ctrl import scu_pkg::*; (
  input  logic         pcie_clk_i,
  input  logic         scu_register_rst_n_s,
  input  scu_mod_rst_t mod_req_i,
  input  scu_mod_rst_t mod_mask_i,
  input  logic         sw_rst_req_i,
  output scu_mod_rst_t mod_rst_o
);

  localparam int STAGES = `SCU_RST_STAGES;

  scu_mod_rst_t              rst_next;
  scu_mod_rst_t [STAGES-1:0] rst_pipe_q;

  // software reset request ignores the mask
  assign rst_next = sw_rst_req_i ? {`SCU_MOD_NUM{1'b1}} : (mod_req_i & ~mod_mask_i);

  always_ff @(posedge pcie_clk_i or negedge scu_register_rst_n_s) begin
    if (!scu_register_rst_n_s) begin
      rst_pipe_q <= '1;   // all modules held
    end else begin
      rst_pipe_q[0] <= rst_next;
      for (int i = 1; i < STAGES; i++) begin
        rst_pipe_q[i] <= rst_pipe_q[i-1];
      end
    end
  end

  assign mod_rst_o = rst_pipe_q[STAGES-1];

  a_sw_rst_all: assert property (
    @(posedge pcie_clk_i) disable iff (!scu_register_rst_n_s)
    sw_rst_req_i [*STAGES] |=> (&mod_rst_o)
  );

endmodule

`default_nettype wire

//--- hdl/scu_uts_counter.sv
//--------------------------------------------------------------------------
// free running timestamp counter, high word frozen by a low word read
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "scu_settings.svh"
`default_nettype none

module scu_uts_counter (
  input  logic                   pcie_clk_i,
  input  logic                   scu_register_rst_n_s,
  input  logic                   clr_i,
  input  logic                   rd_lo_i,
  output logic [`SCU_DATA_W-1:0] uts_lo_o,
  output logic [`SCU_DATA_W-1:0] uts_hi_snap_o
);

  logic [`SCU_UTS_W-1:0]  cnt_q;
  logic [`SCU_DATA_W-1:0] hi_snap_q;

  always_ff @(posedge pcie_clk_i or negedge scu_register_rst_n_s) begin
    if (!scu_register_rst_n_s) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // coherent with the low word returned in the same data phase
  always_ff @(posedge pcie_clk_i) begin
    if (rd_lo_i) begin
      hi_snap_q <= cnt_q[`SCU_UTS_W-1:`SCU_DATA_W];
    end
  end

  assign uts_lo_o      = cnt_q[`SCU_DATA_W-1:0];
  assign uts_hi_snap_o = hi_snap_q;

  a_clr_zero: assert property (
    @(posedge pcie_clk_i) disable iff (!scu_register_rst_n_s)
    clr_i |=> (cnt_q == '0)
  );

endmodule

`default_nettype wire

//--- hdl/scu_top.sv
//--------------------------------------------------------------------------
// system control unit top, ahb-lite registers, interrupts and resets
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "scu_settings.svh"
`default_nettype none

module scu_top import scu_pkg::*; (
  input  logic         pcie_clk_i,
  input  logic         scu_register_rst_n_s,
  input  scu_ahb_req_t ahb_req_i,
  input  logic [2:0]   pcie_int_ack_i,     // line 0 pcie int, 1 rst, 2 wdt
  input  scu_pin_sts_t pin_sts_i,
  output scu_ahb_rsp_t ahb_rsp_o,
  output logic         scu_int_o,
  output logic         sw_int0_o,
  output logic         sw_int1_o,
  output logic         sw_rst_req_prewarning_int_o,
  output logic         pcie_int_o,
  output scu_mod_rst_t mod_rst_o
);

  scu_reg_req_t           reg_req;
  logic [`SCU_DATA_W-1:0] reg_rdata;
  logic                   addr_err;
  scu_irq_ctl_t           irq_ctl;
  scu_irq_sts_t           irq_sts;
  scu_mod_rst_t           mod_req;
  scu_mod_rst_t           mod_mask;
  logic                   sw_rst_req;
  logic                   uts_clr;
  logic                   uts_rd_lo;
  logic [`SCU_DATA_W-1:0] uts_lo;
  logic [`SCU_DATA_W-1:0] uts_hi_snap;

  assign sw_int0_o  = irq_ctl.sw_int[0];
  assign sw_int1_o  = irq_ctl.sw_int[1];
  assign pcie_int_o = irq_ctl.pcie_int;

  scu_ahb_slave u_ahb_slave (
    .pcie_clk_i           (pcie_clk_i          ),
    .scu_register_rst_n_s (scu_register_rst_n_s),
    .ahb_req_i            (ahb_req_i           ),
    .reg_rdata_i          (reg_rdata           ),
    .addr_err_i           (addr_err            ),
    .ahb_rsp_o            (ahb_rsp_o           ),
    .reg_req_o            (reg_req             )
  );

  scu_regfile u_regfile (
    .pcie_clk_i           (pcie_clk_i                 ),
    .scu_register_rst_n_s (scu_register_rst_n_s       ),
    .reg_req_i            (reg_req                    ),
    .irq_sts_i            (irq_sts                    ),
    .mod_rst_i            (mod_rst_o                  ),   // status read back
    .uts_lo_i             (uts_lo                     ),
    .uts_hi_snap_i        (uts_hi_snap                ),
    .pin_sts_i            (pin_sts_i                  ),
    .reg_rdata_o          (reg_rdata                  ),
    .addr_err_o           (addr_err                   ),
    .irq_ctl_o            (irq_ctl                    ),
    .mod_req_o            (mod_req                    ),
    .mod_mask_o           (mod_mask                   ),
    .sw_rst_req_o         (sw_rst_req                 ),
    .prewarn_o            (sw_rst_req_prewarning_int_o),
    .uts_clr_o            (uts_clr                    ),
    .uts_rd_lo_o          (uts_rd_lo                  )
  );

  scu_irq_ctrl u_irq_ctrl (
    .pcie_clk_i           (pcie_clk_i          ),
    .scu_register_rst_n_s (scu_register_rst_n_s),
    .irq_ctl_i            (irq_ctl             ),
    .pcie_int_ack_i       (pcie_int_ack_i      ),
    .irq_sts_o            (irq_sts             ),
    .scu_int_o            (scu_int_o           )
  );

  scu_rst_ctrl u_rst_ctrl (
    .pcie_clk_i           (pcie_clk_i          ),
    .scu_register_rst_n_s (scu_register_rst_n_s),
    .mod_req_i            (mod_req             ),
    .mod_mask_i           (mod_mask            ),
    .sw_rst_req_i         (sw_rst_req          ),
    .mod_rst_o            (mod_rst_o           )
  );

  scu_uts_counter u_uts_counter (
    .pcie_clk_i           (pcie_clk_i          ),
    .scu_register_rst_n_s (scu_register_rst_n_s),
    .clr_i                (uts_clr             ),
    .rd_lo_i              (uts_rd_lo           ),
    .uts_lo_o             (uts_lo              ),
    .uts_hi_snap_o        (uts_hi_snap         )
  );

endmodule

`default_nettype wire

//--- verification/scu_tb.sv
//--------------------------------------------------------------------------
// trace driven testbench of the scu top, run from the project root
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "scu_settings.svh"
`default_nettype none

module scu_tb import scu_pkg::*; ();

  localparam int    BUS_TIMEOUT = 16;   // cycles a data phase may stall
  localparam string TRACE_FILE  = "verification/scu_trace.txt";

  logic         pcie_clk_i;
  logic         scu_register_rst_n_s;
  scu_ahb_req_t ahb_req;
  scu_ahb_rsp_t ahb_rsp;
  logic [2:0]   pcie_int_ack;
  scu_pin_sts_t pin_sts;
  logic         scu_int;
  logic         sw_int0;
  logic         sw_int1;
  logic         prewarn_int;
  logic         pcie_int;
  scu_mod_rst_t mod_rst;

  int           fd;
  int           n_fields;
  int           n_ops;
  string        line;
  logic [7:0]   op;
  logic [31:0]  arg_a;
  logic [31:0]  arg_b;
  logic         first_ready;   // readyout in the first data phase cycle
  logic         first_err;
  logic         last_err;
  logic [31:0]  uts_prev;

  scu_top u_dut (
    .pcie_clk_i                  (pcie_clk_i          ),
    .scu_register_rst_n_s        (scu_register_rst_n_s),
    .ahb_req_i                   (ahb_req             ),
    .pcie_int_ack_i              (pcie_int_ack        ),
    .pin_sts_i                   (pin_sts             ),
    .ahb_rsp_o                   (ahb_rsp             ),
    .scu_int_o                   (scu_int             ),
    .sw_int0_o                   (sw_int0             ),
    .sw_int1_o                   (sw_int1             ),
    .sw_rst_req_prewarning_int_o (prewarn_int         ),
    .pcie_int_o                  (pcie_int            ),
    .mod_rst_o                   (mod_rst             )
  );

  initial pcie_clk_i = 1'b0;
  always #4 pcie_clk_i = ~pcie_clk_i;   // 8 ns period

  //--------------------------------------------------------------------------
  // checking and bus tasks
  //--------------------------------------------------------------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_run($sformatf("FAIL @%0t: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  // direct outputs packed as in the O lines of the trace
  function automatic logic [31:0] outputs_word();
    return {16'b0, mod_rst, pcie_int, prewarn_int, sw_int1, sw_int0, scu_int};
  endfunction

  task automatic bus_access(input logic wr, input logic [23:0] addr,
                            input logic [31:0] wdata, output logic [31:0] data);
    int waited;
    @(negedge pcie_clk_i);
    ahb_req.sel   = 1'b1;
    ahb_req.trans = 2'b10;   // nonseq
    ahb_req.write = wr;
    ahb_req.addr  = addr;
    ahb_req.wdata = '0;
    @(negedge pcie_clk_i);   // data phase
    ahb_req.sel   = 1'b0;
    ahb_req.trans = 2'b00;
    ahb_req.write = 1'b0;
    ahb_req.wdata = wdata;
    first_ready   = ahb_rsp.readyout;
    first_err     = (ahb_rsp.resp == SCU_RESP_ERROR);
    waited        = 0;
    while (!ahb_rsp.readyout) begin
      if (waited == BUS_TIMEOUT) begin
        stop_run($sformatf("bus access to offset %h never completed", addr));
      end
      waited++;
      @(negedge pcie_clk_i);
    end
    last_err = (ahb_rsp.resp == SCU_RESP_ERROR);
    data     = ahb_rsp.rdata;
  endtask

  // okay access has no wait state, error one wait state then error again
  task automatic check_response(input logic expect_err, input string what);
    check_value({31'b0, first_ready}, {31'b0, ~expect_err}, {what, " first readyout"});
    check_value({31'b0, first_err}, {31'b0, expect_err}, {what, " first resp"});
    check_value({31'b0, last_err}, {31'b0, expect_err}, {what, " last resp"});
  endtask

  task automatic run_op(input logic [7:0] kind, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] data;
    case (kind)
      "W": begin
        bus_access(1'b1, a[23:0], b, data);
        check_response(1'b0, $sformatf("write %h", a));
      end
      "R": begin
        bus_access(1'b0, a[23:0], '0, data);
        check_response(1'b0, $sformatf("read %h", a));
        check_value(data, b, $sformatf("read data of %h", a));
      end
      "E": begin
        bus_access(1'b1, a[23:0], b, data);
        check_response(1'b1, $sformatf("unmapped %h", a));
      end
      "A": begin
        @(negedge pcie_clk_i);
        pcie_int_ack = a[2:0];
        @(negedge pcie_clk_i);
        pcie_int_ack = '0;
      end
      "P": begin
        @(negedge pcie_clk_i);
        pin_sts = a[4:0];
      end
      "O": begin
        repeat (3) @(negedge pcie_clk_i);
        check_value(outputs_word(), a, "direct outputs");
      end
      "U": begin
        bus_access(1'b0, `SCU_OFS_UTS_L, '0, data);
        check_response(1'b0, "read UTS_L");
        check_value({31'b0, data <= a}, 32'd1, $sformatf("UTS_L %h at most %h", data, a));
        if (b[0]) begin
          check_value({31'b0, data > uts_prev}, 32'd1,
                      $sformatf("UTS_L %h above %h", data, uts_prev));
        end
        uts_prev = data;
      end
      default: stop_run($sformatf("unknown trace operation %c", kind));
    endcase
  endtask

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------
  initial begin
    ahb_req              = '0;
    ahb_req.ready        = 1'b1;   // master never stalls
    pcie_int_ack         = '0;
    pin_sts              = '0;
    uts_prev             = '0;
    n_ops                = 0;
    scu_register_rst_n_s = 1'b0;
    repeat (3) @(negedge pcie_clk_i);
    check_value({21'b0, mod_rst}, 32'h7FF, "mod_rst_o during reset");
    check_value({31'b0, ahb_rsp.readyout}, 32'd1, "readyout during reset");
    scu_register_rst_n_s = 1'b1;

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      stop_run({"cannot open trace file ", TRACE_FILE});
    end
    while ($fgets(line, fd) != 0) begin
      n_fields = $sscanf(line, "%c %h %h", op, arg_a, arg_b);
      if (n_fields <= 0 || op == "#" || op == "\n" || op == "\r" || op == " ") begin
        continue;   // comment or blank line
      end
      if (n_fields != 3) begin
        stop_run({"malformed trace line: ", line});
      end
      run_op(op, arg_a, arg_b);
      n_ops++;
    end
    $fclose(fd);

    if (n_ops == 0) begin
      stop_run("trace file held no operations");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
hdl/scu_pkg.sv
hdl/scu_ahb_slave.sv
hdl/scu_regfile.sv
hdl/scu_irq_ctrl.sv
hdl/scu_rst_ctrl.sv
hdl/scu_uts_counter.sv
hdl/scu_top.sv
verification/scu_tb.sv

//--- verification/scu_trace.txt
# op offset/value(hex) data/expect(hex): W wr, R rd+cmp, E unmapped, A ack, P pins, O outputs, U uts
# O word: mod_rst[15:5] pcie_int[4] prewarn[3] sw_int1[2] sw_int0[1] scu_int[0]; U col 3 = 1 must grow
R 00 00000000
R 08 00000000
R 0C 00000000
R 14 00000000
R 18 00000000
R 1C 00000000
R 20 00000000
R 24 00000000
R 34 00000000
O 00000000 0
W 08 FFFFFFFF
R 08 00000007
W 08 00000000
E 3C 12345678
E 100 00000000
E 02 FFFFFFFF
# software interrupts
W 00 00000001
R 04 00000002
O 00000002 0
W 08 00000002
O 00000003 0
W 04 00000002
R 04 00000000
O 00000002 0
W 00 00000003
R 04 00000004
O 00000006 0
W 08 00000006
O 00000007 0
W 04 00000006
W 00 00000000
W 08 00000000
O 00000000 0
R 04 00000000
# pcie interrupt and acknowledge
W 0C 00000001
R 0C 00000001
O 00000010 0
A 1 0
R 0C 00000000
R 10 00000001
O 00000000 0
W 0C 00000001
R 10 00000000
A 2 0
A 4 0
R 10 00000006
O 00000010 0
W 0C 00000000
W 14 00000001
R 14 00000001
O 00000008 0
W 14 00000000
# module resets
W 1C FFFFFFFF
R 1C 000007FF
O 0000FFE0 0
W 20 00000555
R 20 00000555
O 00005540 0
R 24 000002AA
W 18 00000001
O 0000FFE0 0
R 24 000007FF
R 18 00000001
W 18 00000000
O 00005540 0
W 1C 00000000
W 20 00000000
O 00000000 0
R 24 00000000
# timestamp counter
U FFFFFFFF 0
R 08 00000000
R 10 00000006
U FFFFFFFF 1
W 30 00000001
U 00000010 0
R 2C 00000000
# pin status
P 15 0
R 34 00000015
P 0A 0
R 34 0000000A
R 10 00000006
